// ==== Makefile ====
# Verilator simulation of the serial memory bus

VERILATOR ?= verilator
TOP       ?= serial_bus_tb
FILELIST  ?= serial_bus.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# the verdict comes from the log, not from the exit status of the run
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -qx ">>> PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/serial_bus_properties.sv ====
//********************************************************************
// Concurrent assertions on the slave responses of the serial bus.
// Bound into every serial_bus_top instance.
//********************************************************************

`timescale 1ns/1ps

module serial_bus_properties #(
    parameter int NUM_SLAVES = 3
) (
    input logic                        clk,
    input logic                        rstN,
    input logic                        busy,
    input bus_types_pkg::slave_resp_t  slave_resp [NUM_SLAVES]
);

    logic [NUM_SLAVES-1:0] sel_vec;
    logic [NUM_SLAVES-1:0] strobe_vec;

    always_comb begin
        for (int i = 0; i < NUM_SLAVES; i++) begin
            sel_vec[i]    = slave_resp[i].selected;
            strobe_vec[i] = slave_resp[i].rd_strobe;
        end
    end

    a_single_select: assert property (
        @(posedge clk) disable iff (!rstN) $onehot0(sel_vec)
    ) else $error("more than one slave selected");

    // a strobed read bit must come from some selected slave
    a_strobe_needs_select: assert property (
        @(posedge clk) disable iff (!rstN) (|strobe_vec) |-> (|sel_vec)
    ) else $error("rd_strobe high with no slave selected");

    a_idle_in_reset: assert property (
        @(posedge clk) !rstN |-> !busy
    ) else $error("master busy during reset");

endmodule

bind serial_bus_top serial_bus_properties #(
    .NUM_SLAVES (NUM_SLAVES)
) u_properties (
    .clk        (clk),
    .rstN       (rstN),
    .busy       (busy),
    .slave_resp (slave_resp)
);

// ==== bench/serial_bus_tb.sv ====
//********************************************************************
// Directed testbench for the serial memory bus. Drives host commands
// into the master, keeps a reference memory per slave id and checks
// every read word against it. A watchdog bounds the run time.
//********************************************************************

`timescale 1ns/1ps

module serial_bus_tb;

    localparam int DW        = bus_cfg_pkg::DATA_WIDTH;
    localparam int MEM_DEPTH = 256;
    // words moved by all tests together, random test at its longest
    localparam int TOTAL_WORDS    = 6 + 16 + 7 + 84 + 8 + 40 * 4 + 11;
    localparam int WORD_CYCLES    = bus_cfg_pkg::HDR_BITS + 2 * DW + 20;
    localparam int TIMEOUT_CYCLES = TOTAL_WORDS * WORD_CYCLES + 500;

    logic                       clk;
    logic                       rstN;
    bus_types_pkg::host_cmd_t   host_cmd;
    logic                       cmd_valid;
    logic [DW-1:0]              wdata;
    logic                       word_take;
    logic [DW-1:0]              rdata;
    logic                       rdata_valid;
    logic                       busy;
    logic                       done;

    // reference memories, index 0 stands for the unused id
    logic [DW-1:0]  ref_mem [4][MEM_DEPTH];
    bit             known   [4][MEM_DEPTH];
    logic [DW-1:0]  wbuf    [16];
    int             err_count;

    tb_clock #(.PERIOD_NS(100.0)) u_clock (.clk(clk));

    serial_bus_top #(
        .NUM_SLAVES (3),
        .MEM_DEPTH  (MEM_DEPTH)
    ) DUT (
        .clk         (clk),
        .rstN        (rstN),
        .host_cmd    (host_cmd),
        .cmd_valid   (cmd_valid),
        .wdata       (wdata),
        .word_take   (word_take),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .busy        (busy),
        .done        (done)
    );

    task automatic check_value(input string name, input logic [DW-1:0] expected,
                               input logic [DW-1:0] actual);
        if (actual !== expected) begin
            err_count++;
            $display("mismatch in %s: expected %h, actual %h", name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "stopped at first error");
        end
    endtask

    // cmd_valid is high for one cycle, starting at the next edge
    task automatic issue_cmd(input logic [1:0] sid, input logic [7:0] addr,
                             input logic wr, input int n);
        bus_types_pkg::host_cmd_t c;
        c.sid    = sid;
        c.addr   = addr;
        c.write  = wr;
        c.nwords = 5'(n);
        @(posedge clk);
        host_cmd  <= c;
        cmd_valid <= 1'b1;
        if (wr) begin
            wdata <= wbuf[0];
        end
        @(negedge clk);
        check_value("idle before command", 32'd0, {31'd0, busy});
        @(posedge clk);
        cmd_valid <= 1'b0;
        @(negedge clk);
        check_value("busy after command", 32'd1, {31'd0, busy});
    endtask

    task automatic write_words(input string name, input logic [1:0] sid,
                               input logic [7:0] addr, input int n);
        int   took;
        int   idx;
        logic finished;
        issue_cmd(sid, addr, 1'b1, n);
        took     = 0;
        finished = 1'b0;
        while (!finished) begin
            @(negedge clk);
            if (done) begin
                finished = 1'b1;
            end else if (word_take) begin
                took++;
                @(posedge clk);
                if (took < n) begin
                    wdata <= wbuf[took];
                end
            end
        end
        check_value({name, " word_take count"}, 32'(n), 32'(took));
        if (sid != 2'd0) begin
            for (int i = 0; i < n; i++) begin
                idx = (int'(addr) + i) % MEM_DEPTH;
                ref_mem[sid][idx] = wbuf[i];
                known[sid][idx]   = 1'b1;
            end
        end
    endtask

    task automatic read_words(input string name, input logic [1:0] sid,
                              input logic [7:0] addr, input int n);
        int   got;
        int   idx;
        logic finished;
        issue_cmd(sid, addr, 1'b0, n);
        got      = 0;
        finished = 1'b0;
        while (!finished) begin
            @(negedge clk);
            if (rdata_valid) begin
                idx = (int'(addr) + got) % MEM_DEPTH;
                if (known[sid][idx]) begin
                    check_value(name, ref_mem[sid][idx], rdata);
                end else begin
                    err_count++;
                    $display("%s read slave %0d address %0d, which was never written",
                             name, sid, idx);
                    $display(">>> FAIL");
                    $fatal(1, "read of unwritten memory");
                end
                got++;
            end
            if (done) begin
                finished = 1'b1;
            end
        end
        check_value({name, " rdata_valid count"}, 32'(n), 32'(got));
    endtask

    task automatic single_word_each_slave();
        for (int s = 1; s <= 3; s++) begin
            wbuf[0] = $urandom;
            write_words("single write", 2'(s), 8'h20, 1);
            read_words("single read", 2'(s), 8'h20, 1);
        end
    endtask

    task automatic burst_round_trip();
        for (int i = 0; i < 8; i++) begin
            wbuf[i] = $urandom;
        end
        write_words("burst write", 2'd2, 8'h40, 8);
        read_words("burst read", 2'd2, 8'h40, 8);
    endtask

    task automatic slave_isolation();
        for (int s = 1; s <= 3; s++) begin
            wbuf[0] = {8'(s), 24'($urandom)};
            write_words("isolation write", 2'(s), 8'h80, 1);
        end
        // no slave answers id 0
        wbuf[0] = 32'hdead_beef;
        write_words("unused id write", 2'd0, 8'h80, 1);
        for (int s = 1; s <= 3; s++) begin
            read_words("isolation read", 2'(s), 8'h80, 1);
        end
    endtask

    task automatic random_commands();
        logic [1:0] sid;
        logic [7:0] addr;
        int         n;
        // every address a random read can reach holds a known word
        for (int s = 1; s <= 3; s++) begin
            for (int b = 0; b < 7; b++) begin
                for (int i = 0; i < 4; i++) begin
                    wbuf[i] = $urandom;
                end
                write_words("window fill", 2'(s), 8'(240 + 4 * b), 4);
            end
        end
        for (int i = 0; i < 4; i++) begin
            wbuf[i] = $urandom;
        end
        write_words("wrap write", 2'd1, 8'hfe, 4);
        read_words("wrap read", 2'd1, 8'hfe, 4);
        for (int c = 0; c < 40; c++) begin
            sid  = 2'($urandom_range(1, 3));
            // window around the top of memory so bursts often wrap
            addr = 8'(240 + $urandom_range(0, 23));
            n    = int'($urandom_range(1, 4));
            if ($urandom_range(0, 1) == 1) begin
                for (int i = 0; i < n; i++) begin
                    wbuf[i] = $urandom;
                end
                write_words("random write", sid, addr, n);
            end else begin
                read_words("random read", sid, addr, n);
            end
        end
    endtask

    task automatic middle_word_rewrite();
        for (int i = 0; i < 5; i++) begin
            wbuf[i] = $urandom;
        end
        write_words("rewrite burst", 2'd3, 8'h60, 5);
        wbuf[0] = ~ref_mem[3][8'h62];
        write_words("rewrite middle", 2'd3, 8'h62, 1);
        read_words("rewrite read", 2'd3, 8'h60, 5);
    endtask

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display(">>> FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rstN      = 1'b0;
        cmd_valid = 1'b0;
        host_cmd  = '0;
        wdata     = '0;
        err_count = 0;
        void'($urandom(87567));
        repeat (3) @(posedge clk);
        rstN <= 1'b1;

        single_word_each_slave();
        burst_round_trip();
        slave_isolation();
        random_commands();
        middle_word_rewrite();

        repeat (2) @(posedge clk);
        if (err_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display(">>> FAIL");
            $fatal(1, "errors found");
        end
    end

endmodule

// ==== bench/tb_clock.sv ====
//********************************************************************
// Free running testbench clock, 100 ns period by default.
//********************************************************************

`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD_NS = 100.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

endmodule

// ==== common/bus_cfg_pkg.sv ====
//********************************************************************
// Fixed widths and protocol constants of the bit-serial memory bus.
// Referenced by scoped name from the type package, the master, the
// slaves and the testbench.
//********************************************************************

package bus_cfg_pkg;

    // bits per memory word
    parameter int DATA_WIDTH = 32;

    // header address field
    parameter int ADDR_WIDTH = 8;

    // slave id field, id 0 is never assigned to a slave
    parameter int SID_WIDTH = 2;

    // every header opens with three ones
    parameter logic [2:0] START_CODE = 3'b111;

    // start + sid + write + burst + addr
    parameter int HDR_BITS = 3 + SID_WIDTH + 2 + ADDR_WIDTH;

endpackage

// ==== common/bus_types_pkg.sv ====
//********************************************************************
// Packed structs carried between host, master, interconnect and
// slaves. Field widths come from the bus configuration package.
//********************************************************************

package bus_types_pkg;

    // serial header, sent msb first so start goes out before sid
    typedef struct packed {
        logic [2:0]                          start;
        logic [bus_cfg_pkg::SID_WIDTH-1:0]   sid;
        logic                                write;
        logic                                burst;
        logic [bus_cfg_pkg::ADDR_WIDTH-1:0]  addr;
    } hdr_t;

    // lines driven by the master to every slave
    typedef struct packed {
        logic control;
        logic wd;
        logic valid;
        logic last;
    } bus_req_t;

    // lines driven by each slave
    typedef struct packed {
        logic rd;
        logic rd_strobe;
        logic ready;
        logic selected;
    } slave_resp_t;

    // host command, nwords runs from 1 to 16
    typedef struct packed {
        logic [bus_cfg_pkg::SID_WIDTH-1:0]   sid;
        logic [bus_cfg_pkg::ADDR_WIDTH-1:0]  addr;
        logic                                write;
        logic [4:0]                          nwords;
    } host_cmd_t;

endpackage

// ==== design/bus_interconnect.sv ====
//********************************************************************
// Fans the master lines out to every slave and returns the response
// of the selected slave. With no slave selected the bus reads idle.
//********************************************************************

`timescale 1ns/1ps

module bus_interconnect #(
    parameter int NUM_SLAVES = 3
) (
    input  bus_types_pkg::bus_req_t     req_in,
    output bus_types_pkg::bus_req_t     req_out [NUM_SLAVES],
    input  bus_types_pkg::slave_resp_t  resp_in [NUM_SLAVES],
    output bus_types_pkg::slave_resp_t  resp_out
);

    always_comb begin
        for (int i = 0; i < NUM_SLAVES; i++) begin
            req_out[i] = req_in;
        end
    end

    // at most one slave is selected, so an OR acts as the mux
    always_comb begin
        bus_types_pkg::slave_resp_t acc;
        acc = '0;
        for (int i = 0; i < NUM_SLAVES; i++) begin
            if (resp_in[i].selected) begin
                acc = acc | resp_in[i];
            end
        end
        if (!acc.selected) begin
            acc.ready = 1'b1;
        end
        resp_out = acc;
    end

endmodule

// ==== design/serial_bus_top.sv ====
//********************************************************************
// Top level of the serial memory bus. One master drives the shared
// lines through the interconnect to NUM_SLAVES memory slaves, whose
// ids run from 1 upward.
//********************************************************************

`timescale 1ns/1ps

module serial_bus_top #(
    parameter int NUM_SLAVES = 3,
    parameter int MEM_DEPTH  = 256
) (
    input  logic                                 clk,
    input  logic                                 rstN,
    input  bus_types_pkg::host_cmd_t             host_cmd,
    input  logic                                 cmd_valid,
    input  logic [bus_cfg_pkg::DATA_WIDTH-1:0]   wdata,
    output logic                                 word_take,
    output logic [bus_cfg_pkg::DATA_WIDTH-1:0]   rdata,
    output logic                                 rdata_valid,
    output logic                                 busy,
    output logic                                 done
);

    bus_types_pkg::bus_req_t     bus_req;
    bus_types_pkg::bus_req_t     slave_req  [NUM_SLAVES];
    bus_types_pkg::slave_resp_t  slave_resp [NUM_SLAVES];
    bus_types_pkg::slave_resp_t  bus_resp;

    serial_master u_master (
        .clk         (clk),
        .rstN        (rstN),
        .host_cmd    (host_cmd),
        .cmd_valid   (cmd_valid),
        .wdata       (wdata),
        .word_take   (word_take),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .busy        (busy),
        .done        (done),
        .bus         (bus_req),
        .resp        (bus_resp)
    );

    bus_interconnect #(
        .NUM_SLAVES (NUM_SLAVES)
    ) u_interconnect (
        .req_in   (bus_req),
        .req_out  (slave_req),
        .resp_in  (slave_resp),
        .resp_out (bus_resp)
    );

    for (genvar i = 0; i < NUM_SLAVES; i++) begin : g_slave
        serial_slave #(
            .SLAVE_ID  (i + 1),
            .MEM_DEPTH (MEM_DEPTH)
        ) u_slave (
            .clk  (clk),
            .rstN (rstN),
            .bus  (slave_req[i]),
            .resp (slave_resp[i])
        );
    end

endmodule

// ==== design/serial_deserializer.sv ====
//********************************************************************
// Collects a serial bit stream, msb first, into a typed payload.
// full pulses for one cycle once NBITS bits have been shifted in.
//********************************************************************

`timescale 1ns/1ps

module serial_deserializer #(
    parameter type payload_t = logic [31:0],
    parameter int  NBITS     = $bits(payload_t)
) (
    input  logic     clk,
    input  logic     rstN,
    input  logic     bit_in,
    input  logic     shift_en,
    input  logic     clear,
    output payload_t payload,
    output logic     full
);

    localparam int CNT_W = $clog2(NBITS + 1);

    logic [NBITS-1:0] shreg;
    logic [CNT_W-1:0] count;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            count <= '0;
            full  <= 1'b0;
        end else begin
            full <= 1'b0;
            // a bit arriving with clear counts as the first of a new payload
            if (clear) begin
                count <= shift_en ? CNT_W'(1) : '0;
            end else if (shift_en) begin
                if (count == CNT_W'(NBITS - 1)) begin
                    count <= '0;
                    full  <= 1'b1;
                end else begin
                    count <= count + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (shift_en) begin
            shreg <= {shreg[NBITS-2:0], bit_in};
        end
    end

    assign payload = payload_t'(shreg);

endmodule

// ==== master/serial_master.sv ====
//********************************************************************
// Bus master. Accepts one host command at a time, shifts its header
// out on control, streams write words on wd and gathers read bits
// from the selected slave into words. done marks command completion.
//********************************************************************

`timescale 1ns/1ps

module serial_master (
    input  logic                                 clk,
    input  logic                                 rstN,
    input  bus_types_pkg::host_cmd_t             host_cmd,
    input  logic                                 cmd_valid,
    input  logic [bus_cfg_pkg::DATA_WIDTH-1:0]   wdata,
    output logic                                 word_take,
    output logic [bus_cfg_pkg::DATA_WIDTH-1:0]   rdata,
    output logic                                 rdata_valid,
    output logic                                 busy,
    output logic                                 done,
    output bus_types_pkg::bus_req_t              bus,
    input  bus_types_pkg::slave_resp_t           resp
);

    localparam int DW    = bus_cfg_pkg::DATA_WIDTH;
    localparam int HB    = bus_cfg_pkg::HDR_BITS;
    localparam int CNT_W = $clog2(DW);

    typedef enum logic [1:0] {S_IDLE, S_HDR, S_WDATA, S_RWAIT} state_t;

    state_t                         state;
    bus_types_pkg::host_cmd_t       cmd;
    bus_types_pkg::hdr_t            hdr_next;
    logic [HB-1:0]                  hdr_sr;
    logic [DW-1:0]                  word_sr;
    logic [CNT_W-1:0]               bit_cnt;
    logic [$bits(cmd.nwords)-1:0]   word_cnt;
    logic [$bits(cmd.nwords)-1:0]   words_rx;
    logic                           accept;
    logic                           hdr_end;
    logic                           word_end;
    logic                           final_word;
    logic                           last_rx;
    logic                           rx_full;

    assign accept     = cmd_valid && (state == S_IDLE);
    assign hdr_end    = (state == S_HDR) && (bit_cnt == CNT_W'(HB - 1));
    assign word_end   = (state == S_WDATA) && (bit_cnt == CNT_W'(DW - 1));
    assign final_word = word_cnt == cmd.nwords - 1'b1;
    assign last_rx    = words_rx == cmd.nwords - 1'b1;

    // first word is taken at header end, later ones at each word end
    assign word_take = (hdr_end && cmd.write) || (word_end && !final_word);

    always_comb begin
        hdr_next.start = bus_cfg_pkg::START_CODE;
        hdr_next.sid   = host_cmd.sid;
        hdr_next.write = host_cmd.write;
        hdr_next.burst = host_cmd.nwords > 5'd1;
        hdr_next.addr  = host_cmd.addr;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cmd    <= host_cmd;
            hdr_sr <= hdr_next;
        end else if (state == S_HDR) begin
            hdr_sr <= hdr_sr << 1;
        end
        if (word_take) begin
            word_sr <= wdata;
        end else if (state == S_WDATA) begin
            word_sr <= word_sr << 1;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state    <= S_IDLE;
            bit_cnt  <= '0;
            word_cnt <= '0;
            words_rx <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        bit_cnt <= '0;
                        state   <= S_HDR;
                    end
                end
                S_HDR: begin
                    if (hdr_end) begin
                        bit_cnt  <= '0;
                        word_cnt <= '0;
                        words_rx <= '0;
                        state    <= cmd.write ? S_WDATA : S_RWAIT;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                S_WDATA: begin
                    if (word_end) begin
                        bit_cnt  <= '0;
                        word_cnt <= word_cnt + 1'b1;
                        if (final_word) begin
                            done  <= 1'b1;
                            state <= S_IDLE;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                S_RWAIT: begin
                    // slave paces the words, just count them
                    if (rx_full) begin
                        words_rx <= words_rx + 1'b1;
                        if (last_rx) begin
                            done  <= 1'b1;
                            state <= S_IDLE;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    serial_deserializer #(
        .payload_t (logic [DW-1:0]),
        .NBITS     (DW)
    ) u_rx_word (
        .clk      (clk),
        .rstN     (rstN),
        .bit_in   (resp.rd),
        .shift_en (resp.rd_strobe),
        .clear    (accept),
        .payload  (rdata),
        .full     (rx_full)
    );

    assign rdata_valid = rx_full;
    assign busy        = state != S_IDLE;

    assign bus.control = (state == S_HDR) & hdr_sr[HB-1];
    assign bus.wd      = (state == S_WDATA) & word_sr[DW-1];
    assign bus.valid   = state == S_WDATA;
    // write: final bit only, read: whole final word until done
    assign bus.last    = (word_end & final_word) | ((state == S_RWAIT) & last_rx);

endmodule

// ==== serial_bus.f ====
common/bus_cfg_pkg.sv
common/bus_types_pkg.sv
design/serial_deserializer.sv
master/serial_master.sv
slave/serial_slave.sv
design/bus_interconnect.sv
design/serial_bus_top.sv
bench/tb_clock.sv
bench/serial_bus_properties.sv
bench/serial_bus_tb.sv

// ==== slave/serial_slave.sv ====
//********************************************************************
// Memory slave on the serial bus. Watches every header, serves the
// ones carrying its own id, and performs single or burst writes and
// reads on a local memory that wraps at MEM_DEPTH.
//********************************************************************

`timescale 1ns/1ps

module serial_slave #(
    parameter int SLAVE_ID  = 1,
    parameter int MEM_DEPTH = 256
) (
    input  logic                        clk,
    input  logic                        rstN,
    input  bus_types_pkg::bus_req_t     bus,
    output bus_types_pkg::slave_resp_t  resp
);

    localparam int DW    = bus_cfg_pkg::DATA_WIDTH;
    localparam int IDX_W = $clog2(MEM_DEPTH);
    localparam int CNT_W = $clog2(DW);
    localparam logic [bus_cfg_pkg::SID_WIDTH-1:0] MY_SID = bus_cfg_pkg::SID_WIDTH'(SLAVE_ID);

    typedef enum logic [1:0] {S_IDLE, S_WRITE, S_FETCH, S_SEND} state_t;

    state_t                               state;
    bus_types_pkg::hdr_t                  hdr;
    logic                                 hdr_full;
    logic                                 hdr_busy;
    logic                                 hdr_shift;
    logic                                 hdr_hit;
    logic [DW-1:0]                        wr_word;
    logic                                 wr_full;
    logic [bus_cfg_pkg::ADDR_WIDTH-1:0]   addr;
    logic                                 burst;
    logic                                 last_seen;
    logic [CNT_W-1:0]                     bit_cnt;
    logic [DW-1:0]                        out_sr;
    logic [IDX_W-1:0]                     mem_idx;
    logic [DW-1:0]                        mem [MEM_DEPTH];

    // header capture starts on the rising control bit
    assign hdr_shift = bus.control | (hdr_busy & ~hdr_full);

    serial_deserializer #(
        .payload_t (bus_types_pkg::hdr_t),
        .NBITS     (bus_cfg_pkg::HDR_BITS)
    ) u_hdr (
        .clk      (clk),
        .rstN     (rstN),
        .bit_in   (bus.control),
        .shift_en (hdr_shift),
        .clear    (hdr_full),
        .payload  (hdr),
        .full     (hdr_full)
    );

    // write data may begin in the cycle the header completes
    serial_deserializer #(
        .payload_t (logic [DW-1:0]),
        .NBITS     (DW)
    ) u_wr_word (
        .clk      (clk),
        .rstN     (rstN),
        .bit_in   (bus.wd),
        .shift_en (bus.valid),
        .clear    (hdr_full),
        .payload  (wr_word),
        .full     (wr_full)
    );

    assign hdr_hit = hdr_full && (state == S_IDLE)
                     && (hdr.start == bus_cfg_pkg::START_CODE) && (hdr.sid == MY_SID);

    assign mem_idx = IDX_W'(int'(addr) % MEM_DEPTH);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= S_IDLE;
            hdr_busy  <= 1'b0;
            addr      <= '0;
            burst     <= 1'b0;
            last_seen <= 1'b0;
            bit_cnt   <= '0;
        end else begin
            hdr_busy <= (hdr_busy | bus.control) & ~hdr_full;
            case (state)
                S_IDLE: begin
                    last_seen <= 1'b0;
                    if (hdr_hit) begin
                        addr  <= hdr.addr;
                        burst <= hdr.burst;
                        state <= hdr.write ? S_WRITE : S_FETCH;
                    end
                end
                S_WRITE: begin
                    if (bus.valid && bus.last) begin
                        last_seen <= 1'b1;
                    end
                    if (wr_full) begin
                        addr <= addr + 1'b1;
                        if (!burst || last_seen) begin
                            state <= S_IDLE;
                        end
                    end
                end
                S_FETCH: begin
                    bit_cnt <= '0;
                    state   <= S_SEND;
                end
                S_SEND: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bus.last) begin
                        last_seen <= 1'b1;
                    end
                    if (bit_cnt == CNT_W'(DW - 1)) begin
                        addr      <= addr + 1'b1;
                        last_seen <= 1'b0;
                        // master raises last for the whole final word
                        if (!burst || last_seen || bus.last) begin
                            state <= S_IDLE;
                        end else begin
                            state <= S_FETCH;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // memory and read shift register
    always_ff @(posedge clk) begin
        if (state == S_WRITE && wr_full) begin
            mem[mem_idx] <= wr_word;
        end
        if (state == S_FETCH) begin
            out_sr <= mem[mem_idx];
        end else if (state == S_SEND) begin
            out_sr <= out_sr << 1;
        end
    end

    assign resp.rd        = out_sr[DW-1] & (state == S_SEND);
    assign resp.rd_strobe = state == S_SEND;
    assign resp.ready     = state == S_IDLE;
    assign resp.selected  = state != S_IDLE;

endmodule
